/* mem_subsystem.f */
+incdir+hw
hw/cpu_pkg.sv
hw/dmem_if.sv
hw/mem_access_ctrl.sv
hw/store_align.sv
hw/load_align.sv
hw/data_ram.sv
hw/mem_stage_regs.sv
hw/mem_subsystem.sv
tests/mem_subsystem_tb.sv

/* tests/mem_subsystem_tb.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module mem_subsystem_tb import cpu_pkg::*; ();

	localparam int SEND_LIMIT	= 100;
	localparam int DRAIN_LIMIT	= 200;

	typedef struct packed {
		logic	[`XLEN-1:0]	pc;
		logic	[31:0]		ir;
		logic				ill;
		logic	[4:0]		rd;
		logic	[`XLEN-1:0]	data;
		logic				write;
		logic				mis;
		logic	[1:0]		bresp;
		logic	[1:0]		rresp;
	} exp_t;

	logic				clk = 1'b0;
	logic				reset;
	logic				valid_in;
	logic				ready_out;
	logic				valid_out;
	logic				ready_in;
	logic	[`XLEN-1:0]	pc_ex;
	logic	[31:0]		ir_ex;
	logic	[4:0]		rd_addr_ex;
	logic	[`XLEN-1:0]	alu_result_ex;
	logic	[`XLEN-1:0]	store_data_ex;
	wb_src_t			wb_src_ex;
	mem_op_t			mem_op_ex;
	logic				illegal_inst_ex;
	logic	[`XLEN-1:0]	pc_mem;
	logic	[31:0]		ir_mem;
	logic	[4:0]		rd_addr_mem;
	logic	[`XLEN-1:0]	rd_data_mem;
	logic				rd_write_mem;
	logic				illegal_inst_mem;
	logic				misaligned_data_addr_mem;
	logic	[1:0]		bresp_mem;
	logic	[1:0]		rresp_mem;

	logic	[7:0]		ref_mem [4*`DMEM_WORDS];	// Byte image of the data RAM.
	exp_t				exp_q [$];
	integer				seed = 32'hefc3_d8ee;
	logic	[`XLEN-1:0]	pc;
	int					ready_mode = 0;		// 0 high, 1 random, 2 low.
	logic				ready_next = 1'b1;
	logic				held = 1'b0;
	logic	[`XLEN-1:0]	held_pc;
	logic	[`XLEN-1:0]	held_data;
	int					checks;
	int					errors;
	int					errors_before;
	int					tests_run;

	mem_subsystem dut_i (.*);

	always #20 clk = ~clk;

	always @(negedge clk) begin
		logic [31:0] r;
		r = $random(seed);
		ready_next = ready_mode == 0 || (ready_mode == 1 && r[1:0] != 2'b00);
	end

	always @(posedge clk) begin
		#2;
		ready_in = ready_next;
	end

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		checks++;
		assert (actual === expected)
		else begin
			$display("MISMATCH at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
			errors++;
		end
	endtask

	task automatic abort_run(input string why);
		$display("Timeout at %0t ns: %s", $time, why);
		$display("Simulation failed");
		$finish;
	endtask

	function automatic logic [`XLEN-1:0] fill_word(input logic [`XLEN-1:0] a);
		return (a * 32'h9e37_79b1) ^ 32'h5bd1_e995;
	endfunction

	function automatic logic [`XLEN-1:0] random_word_addr();
		logic [31:0] r;
		r = $random(seed);
		return (r % `DMEM_WORDS) * 4;
	endfunction

	// Expected MEM/WB contents; stores also update the byte image.
	function automatic exp_t predict(input wb_src_t src, input mem_op_t op,
			input logic [`XLEN-1:0] addr, input logic [`XLEN-1:0] sdata, input logic [4:0] rd);
		exp_t			e;
		logic			is_st;
		logic			in_rng;
		logic	[31:0]	word;
		int				nbytes;
		e = '{pc: pc, ir: pc ^ 32'h0000_0003, ill: pc[2], rd: rd, data: addr,
			write: rd != 0, mis: 1'b0, bresp: `RESP_OKAY, rresp: `RESP_OKAY};
		if (src == SEL_MEM) begin
			is_st	= op inside {MEM_SB, MEM_SH, MEM_SW};
			nbytes	= op inside {MEM_LB, MEM_LBU, MEM_SB} ? 1 :
				op inside {MEM_LH, MEM_LHU, MEM_SH} ? 2 : 4;
			in_rng	= (addr >> 2) < `DMEM_WORDS;
			e.mis	= (addr & (nbytes - 1)) != 0;
			e.write	= rd != 0 && !is_st && !e.mis;
			if (is_st)
				e.data = '0;
			if (!e.mis && is_st) begin
				e.bresp = in_rng ? `RESP_OKAY : `RESP_SLVERR;
				for (int i = 0; i < nbytes && in_rng; i++)
					ref_mem[addr + i] = sdata[8*i +: 8];
			end else if (!e.mis) begin
				e.rresp	= in_rng ? `RESP_OKAY : `RESP_SLVERR;
				word	= '0;
				for (int i = 0; i < nbytes && in_rng; i++)
					word[8*i +: 8] = ref_mem[addr + i];
				if (op == MEM_LB && word[7])
					word[31:8] = '1;
				if (op == MEM_LH && word[15])
					word[31:16] = '1;
				e.data = word;
			end
		end
		return e;
	endfunction

	task automatic send(input wb_src_t src, input mem_op_t op, input logic [`XLEN-1:0] addr,
			input logic [`XLEN-1:0] sdata, input logic [4:0] rd);
		exp_t	e;
		int		cycles;
		e = predict(src, op, addr, sdata, rd);
		exp_q.push_back(e);
		pc_ex			= pc;
		ir_ex			= e.ir;
		illegal_inst_ex	= e.ill;
		rd_addr_ex		= rd;
		alu_result_ex	= addr;
		store_data_ex	= sdata;
		wb_src_ex		= src;
		mem_op_ex		= op;
		valid_in		= 1'b1;
		cycles			= 0;
		@(posedge clk);
		while (!ready_out) begin
			if (cycles == SEND_LIMIT)
				abort_run("instruction was never accepted");
			else begin
				@(posedge clk);
				cycles++;
			end
		end
		#2;
		valid_in = 1'b0;
		pc = pc + 4;
	endtask

	task automatic drain_all();
		int cycles;
		cycles = 0;
		while (exp_q.size() != 0) begin
			if (cycles == DRAIN_LIMIT)
				abort_run("writeback outputs never drained");
			else begin
				@(posedge clk);
				#2;
				cycles++;
			end
		end
	endtask

	task automatic wait_for_hold();
		int cycles;
		cycles = 0;
		while (dut_i.ctrl_i.state != HOLD) begin
			if (cycles == SEND_LIMIT)
				abort_run("controller never entered HOLD");
			else begin
				@(posedge clk);
				cycles++;
			end
		end
	endtask

	task automatic end_test(input string name);
		drain_all();
		tests_run++;
		$display("Test %0d, %s: %0d errors", tests_run, name, errors - errors_before);
		errors_before = errors;
	endtask

	// Each drain is compared with the oldest outstanding instruction.
	always @(posedge clk) begin
		exp_t e;
		if (!reset && valid_out && ready_in) begin
			if (exp_q.size() == 0) begin
				$display("Output at %0t ns with no instruction outstanding", $time);
				errors++;
			end else begin
				e = exp_q.pop_front();
				check_value("pc_mem", pc_mem, e.pc);
				check_value("ir_mem", ir_mem, e.ir);
				check_value("illegal_inst_mem", illegal_inst_mem, e.ill);
				check_value("rd_addr_mem", rd_addr_mem, e.rd);
				check_value("rd_data_mem", rd_data_mem, e.data);
				check_value("rd_write_mem", rd_write_mem, e.write);
				check_value("misaligned_data_addr_mem", misaligned_data_addr_mem, e.mis);
				check_value("bresp_mem", bresp_mem, e.bresp);
				check_value("rresp_mem", rresp_mem, e.rresp);
			end
		end
	end

	always @(posedge clk) begin
		if (held) begin		// Stalled by writeback on the previous edge.
			check_value("valid_out", valid_out, 1'b1);
			check_value("pc_mem", pc_mem, held_pc);
			check_value("rd_data_mem", rd_data_mem, held_data);
		end
		held		= !reset && valid_out && !ready_in;
		held_pc		= pc_mem;
		held_data	= rd_data_mem;
	end

	initial begin
		logic [`XLEN-1:0]	a;
		logic [31:0]		r;
		reset			= 1'b1;
		valid_in		= 1'b0;
		ready_in		= 1'b1;
		pc_ex			= '0;
		ir_ex			= '0;
		rd_addr_ex		= '0;
		alu_result_ex	= '0;
		store_data_ex	= '0;
		wb_src_ex		= SEL_ALU;
		mem_op_ex		= MEM_LW;
		illegal_inst_ex	= 1'b0;
		pc				= 32'h0000_1000;
		checks			= 0;
		errors			= 0;
		errors_before	= 0;
		tests_run		= 0;
		repeat (4) @(posedge clk);
		#2;
		reset = 1'b0;
		check_value("valid_out", valid_out, 1'b0);

		for (int w = 0; w < `DMEM_WORDS; w++)
			send(SEL_MEM, MEM_SW, w * 4, fill_word(w * 4), 5'd0);

		for (int i = 0; i < 16; i++) begin
			a = random_word_addr();
			send(SEL_MEM, MEM_SW, a, $random(seed), 5'd0);
			send(SEL_MEM, MEM_LW, a, '0, 5'(i + 1));
		end
		end_test("store and load word");

		for (int i = 0; i < 4; i++) begin
			a = random_word_addr();
			send(SEL_MEM, MEM_SW, a, i[0] ? 32'h7f80_01fe : 32'h807f_ff01, 5'd0);
			for (int off = 0; off < 4; off++) begin
				send(SEL_MEM, MEM_LB, a + off, '0, 5'd3);
				send(SEL_MEM, MEM_LBU, a + off, '0, 5'd4);
			end
			for (int off = 0; off < 4; off += 2) begin
				send(SEL_MEM, MEM_LH, a + off, '0, 5'd5);
				send(SEL_MEM, MEM_LHU, a + off, '0, 5'd6);
			end
		end
		end_test("byte and halfword loads");

		a = random_word_addr();
		for (int off = 0; off < 4; off++) begin
			send(SEL_MEM, MEM_SB, a + off, $random(seed), 5'd0);
			send(SEL_MEM, MEM_LW, a, '0, 5'd7);
		end
		for (int off = 0; off < 4; off += 2) begin
			send(SEL_MEM, MEM_SH, a + off, $random(seed), 5'd0);
			send(SEL_MEM, MEM_LW, a, '0, 5'd7);
		end
		end_test("byte and halfword stores");

		a = random_word_addr();
		send(SEL_MEM, MEM_LH, a + 1, '0, 5'd8);
		send(SEL_MEM, MEM_LHU, a + 3, '0, 5'd8);
		send(SEL_MEM, MEM_SH, a + 1, 32'hdead_beef, 5'd0);
		for (int off = 1; off < 4; off++) begin
			send(SEL_MEM, MEM_LW, a + off, '0, 5'd9);
			send(SEL_MEM, MEM_SW, a + off, 32'hdead_beef, 5'd0);
		end
		send(SEL_MEM, MEM_LW, a, '0, 5'd10);
		send(SEL_MEM, MEM_LW, a + 4, '0, 5'd10);
		end_test("misaligned access");

		// Out-of-range words alias onto low words if the write is not dropped.
		send(SEL_MEM, MEM_SW, 32'h0000_0400, 32'h1234_5678, 5'd0);
		send(SEL_MEM, MEM_LW, 32'h0000_0400, '0, 5'd11);
		send(SEL_MEM, MEM_SB, 32'h8000_0005, 32'h0000_00aa, 5'd0);
		send(SEL_MEM, MEM_LB, 32'h8000_0005, '0, 5'd12);
		send(SEL_MEM, MEM_LW, 32'h0000_0000, '0, 5'd13);
		send(SEL_MEM, MEM_LW, 32'h0000_0004, '0, 5'd14);
		end_test("out of range address");

		ready_mode = 1;
		for (int i = 0; i < 40; i++) begin
			r = $random(seed);
			if (i % 10 == 9)
				send(SEL_MEM, MEM_LW, random_word_addr(), '0, 5'd15);
			else if (i % 8 == 7)
				send(SEL_IMM, MEM_LW, r, '0, r[12:8]);
			else
				send(SEL_ALU, MEM_LW, r, '0, r[12:8]);
		end
		ready_mode = 0;
		drain_all();
		ready_mode = 2;
		a = random_word_addr();
		fork
			send(SEL_MEM, MEM_LW, a, '0, 5'd16);
			begin
				wait_for_hold();
				repeat (3) @(posedge clk);
				#2;
				ready_mode = 0;
			end
		join
		end_test("writeback backpressure");

		$display("Tests: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

/* hw/mem_subsystem.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module mem_subsystem import cpu_pkg::*; (
	input	logic				clk,
	input	logic				reset,
	input	logic				valid_in,
	output	logic				ready_out,
	output	logic				valid_out,
	input	logic				ready_in,
	input	logic	[`XLEN-1:0]	pc_ex,
	input	logic	[31:0]		ir_ex,
	input	logic	[4:0]		rd_addr_ex,
	input	logic	[`XLEN-1:0]	alu_result_ex,		// Also the data address.
	input	logic	[`XLEN-1:0]	store_data_ex,
	input	wb_src_t			wb_src_ex,
	input	mem_op_t			mem_op_ex,
	input	logic				illegal_inst_ex,
	output	logic	[`XLEN-1:0]	pc_mem,
	output	logic	[31:0]		ir_mem,
	output	logic	[4:0]		rd_addr_mem,
	output	logic	[`XLEN-1:0]	rd_data_mem,
	output	logic				rd_write_mem,
	output	logic				illegal_inst_mem,
	output	logic				misaligned_data_addr_mem,
	output	logic	[1:0]		bresp_mem,
	output	logic	[1:0]		rresp_mem
);

	logic					stall;
	logic					misaligned;
	logic	[`XLEN-1:0]		rsp_data;
	logic	[1:0]			rsp_code;
	logic	[`XLEN-1:0]		wdata_lane;
	logic	[`XLEN/8-1:0]	wstrb_lane;
	logic	[`XLEN-1:0]		load_value;

	dmem_if bus ();

	store_align store_align_i (
		.mem_op_ex		(mem_op_ex),
		.addr_ex		(alu_result_ex[1:0]),
		.store_data_ex	(store_data_ex),
		.wdata_lane		(wdata_lane),
		.wstrb_lane		(wstrb_lane)
	);

	mem_access_ctrl ctrl_i (
		.clk		(clk),
		.reset		(reset),
		.valid_in	(valid_in),
		.ready_in	(ready_in),
		.wb_src_ex	(wb_src_ex),
		.mem_op_ex	(mem_op_ex),
		.addr_ex	(alu_result_ex),
		.wdata_lane	(wdata_lane),
		.wstrb_lane	(wstrb_lane),
		.bus		(bus.master),
		.stall		(stall),
		.misaligned	(misaligned),
		.rsp_data	(rsp_data),
		.rsp_code	(rsp_code)
	);

	data_ram ram_i (
		.clk	(clk),
		.reset	(reset),
		.bus	(bus.slave)
	);

	load_align load_align_i (
		.mem_op_ex	(mem_op_ex),
		.addr_ex	(alu_result_ex[1:0]),
		.rsp_data	(rsp_data),
		.load_value	(load_value)
	);

	mem_stage_regs regs_i (
		.clk						(clk),
		.reset						(reset),
		.valid_in					(valid_in),
		.ready_out					(ready_out),
		.valid_out					(valid_out),
		.ready_in					(ready_in),
		.stall						(stall),
		.pc_ex						(pc_ex),
		.ir_ex						(ir_ex),
		.rd_addr_ex					(rd_addr_ex),
		.alu_result_ex				(alu_result_ex),
		.wb_src_ex					(wb_src_ex),
		.mem_op_ex					(mem_op_ex),
		.illegal_inst_ex			(illegal_inst_ex),
		.load_value					(load_value),
		.rsp_code					(rsp_code),
		.misaligned					(misaligned),
		.pc_mem						(pc_mem),
		.ir_mem						(ir_mem),
		.rd_addr_mem				(rd_addr_mem),
		.rd_data_mem				(rd_data_mem),
		.rd_write_mem				(rd_write_mem),
		.illegal_inst_mem			(illegal_inst_mem),
		.misaligned_data_addr_mem	(misaligned_data_addr_mem),
		.bresp_mem					(bresp_mem),
		.rresp_mem					(rresp_mem)
	);

endmodule

/* hw/mem_stage_regs.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module mem_stage_regs import cpu_pkg::*; (
	input	logic				clk,
	input	logic				reset,
	input	logic				valid_in,
	output	logic				ready_out,
	output	logic				valid_out,
	input	logic				ready_in,
	input	logic				stall,
	input	logic	[`XLEN-1:0]	pc_ex,
	input	logic	[31:0]		ir_ex,
	input	logic	[4:0]		rd_addr_ex,
	input	logic	[`XLEN-1:0]	alu_result_ex,
	input	wb_src_t			wb_src_ex,
	input	mem_op_t			mem_op_ex,
	input	logic				illegal_inst_ex,
	input	logic	[`XLEN-1:0]	load_value,
	input	logic	[1:0]		rsp_code,
	input	logic				misaligned,
	output	logic	[`XLEN-1:0]	pc_mem,
	output	logic	[31:0]		ir_mem,
	output	logic	[4:0]		rd_addr_mem,
	output	logic	[`XLEN-1:0]	rd_data_mem,
	output	logic				rd_write_mem,
	output	logic				illegal_inst_mem,
	output	logic				misaligned_data_addr_mem,
	output	logic	[1:0]		bresp_mem,
	output	logic	[1:0]		rresp_mem
);

	logic				is_mem;
	logic				is_store;
	logic				accessed;
	logic	[`XLEN-1:0]	rd_data_next;

	assign ready_out	= ready_in && !stall;
	assign is_mem		= wb_src_ex == SEL_MEM;
	assign is_store		= is_mem && is_store_op(mem_op_ex);
	assign accessed		= is_mem && !misaligned;	// Access really went to the bus.

	always_comb begin
		if (is_store)
			rd_data_next = '0;
		else if (accessed)
			rd_data_next = load_value;
		else
			rd_data_next = alu_result_ex;
	end

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			valid_out					<= 1'b0;
			pc_mem						<= '0;
			ir_mem						<= '0;
			rd_addr_mem					<= '0;
			rd_data_mem					<= '0;
			rd_write_mem				<= 1'b0;
			illegal_inst_mem			<= 1'b0;
			misaligned_data_addr_mem	<= 1'b0;
			bresp_mem					<= `RESP_OKAY;
			rresp_mem					<= `RESP_OKAY;
		end else if (valid_in && ready_out) begin
			valid_out					<= 1'b1;
			pc_mem						<= pc_ex;
			ir_mem						<= ir_ex;
			rd_addr_mem					<= rd_addr_ex;
			rd_data_mem					<= rd_data_next;
			rd_write_mem				<= rd_addr_ex != 5'd0 && !is_store && !misaligned;
			illegal_inst_mem			<= illegal_inst_ex;
			misaligned_data_addr_mem	<= misaligned;
			bresp_mem					<= (accessed && is_store) ? rsp_code : `RESP_OKAY;
			rresp_mem					<= (accessed && !is_store) ? rsp_code : `RESP_OKAY;
		end else if (valid_out && ready_in) begin
			// Drained with nothing behind it, so present a bubble.
			valid_out					<= 1'b0;
			pc_mem						<= '0;
			ir_mem						<= '0;
			rd_addr_mem					<= '0;
			rd_data_mem					<= '0;
			rd_write_mem				<= 1'b0;
			illegal_inst_mem			<= 1'b0;
			misaligned_data_addr_mem	<= 1'b0;
			bresp_mem					<= `RESP_OKAY;
			rresp_mem					<= `RESP_OKAY;
		end
	end

endmodule

/* hw/data_ram.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module data_ram (
	input	logic	clk,
	input	logic	reset,
	dmem_if.slave	bus
);

	localparam int IDX_W = $clog2(`DMEM_WORDS);
	localparam int CNT_W = $clog2(`DMEM_LATENCY + 1);

	logic	[`XLEN-1:0]	mem [`DMEM_WORDS];
	logic				req;
	logic	[`XLEN-1:0]	req_addr;
	logic	[IDX_W-1:0]	idx;
	logic				in_range;
	logic	[CNT_W-1:0]	delay;
	logic				write_q;
	logic				fire;
	logic				fire_write;
	logic	[`XLEN-1:0]	rdata_q;
	logic	[1:0]		resp_q;

	assign req			= bus.awvalid || bus.arvalid;
	assign req_addr		= bus.awvalid ? bus.awaddr : bus.araddr;
	assign idx			= req_addr[IDX_W+1:2];
	assign in_range		= req_addr[`XLEN-1:2] < (`XLEN-2)'(`DMEM_WORDS);

	// Response becomes valid on the edge that completes the latency.
	assign fire			= req ? (`DMEM_LATENCY == 1) : (delay == CNT_W'(1));
	assign fire_write	= req ? bus.awvalid : write_q;

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			delay		<= '0;
			write_q		<= 1'b0;
			bus.bvalid	<= 1'b0;
			bus.rvalid	<= 1'b0;
		end else begin
			if (req) begin
				delay	<= CNT_W'(`DMEM_LATENCY - 1);
				write_q	<= bus.awvalid;
			end else if (delay != '0) begin
				delay	<= delay - 1'b1;
			end

			if (fire && fire_write)
				bus.bvalid <= 1'b1;
			else if (bus.bready)
				bus.bvalid <= 1'b0;		// Consumed.

			if (fire && !fire_write)
				bus.rvalid <= 1'b1;
			else if (bus.rready)
				bus.rvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (req) begin
			rdata_q	<= (in_range && bus.arvalid) ? mem[idx] : '0;
			resp_q	<= in_range ? `RESP_OKAY : `RESP_SLVERR;
		end
		if (bus.awvalid && in_range) begin
			for (int b = 0; b < `XLEN/8; b++) begin
				if (bus.wstrb[b])
					mem[idx][8*b +: 8] <= bus.wdata[8*b +: 8];
			end
		end
	end

	assign bus.rdata	= rdata_q;
	assign bus.rresp	= resp_q;
	assign bus.bresp	= resp_q;

endmodule

/* hw/load_align.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module load_align import cpu_pkg::*; (
	input	mem_op_t			mem_op_ex,
	input	logic	[1:0]		addr_ex,
	input	logic	[`XLEN-1:0]	rsp_data,
	output	logic	[`XLEN-1:0]	load_value
);

	logic	[`XLEN-1:0]	shifted;

	// Addressed byte moves down to lane 0.
	assign shifted = rsp_data >> {addr_ex, 3'b000};

	always_comb begin
		case (mem_op_ex)
		MEM_LB: begin
			load_value = {{(`XLEN-8){shifted[7]}}, shifted[7:0]};
		end
		MEM_LH: begin
			load_value = {{(`XLEN-16){shifted[15]}}, shifted[15:0]};
		end
		MEM_LBU: begin
			load_value = {{(`XLEN-8){1'b0}}, shifted[7:0]};
		end
		MEM_LHU: begin
			load_value = {{(`XLEN-16){1'b0}}, shifted[15:0]};
		end
		default: begin
			load_value = shifted;	// LW, offset is zero when aligned.
		end
		endcase
	end

endmodule

/* hw/store_align.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module store_align import cpu_pkg::*; (
	input	mem_op_t				mem_op_ex,
	input	logic	[1:0]			addr_ex,		// Byte offset within the word.
	input	logic	[`XLEN-1:0]		store_data_ex,
	output	logic	[`XLEN-1:0]		wdata_lane,
	output	logic	[`XLEN/8-1:0]	wstrb_lane
);

	always_comb begin
		wdata_lane = '0;
		wstrb_lane = '0;
		case (mem_op_ex)
		MEM_SB: begin
			wdata_lane = {(`XLEN/8){store_data_ex[7:0]}};
			wstrb_lane = (`XLEN/8)'(1) << addr_ex;
		end
		MEM_SH: begin
			wdata_lane = {(`XLEN/16){store_data_ex[15:0]}};
			wstrb_lane = (`XLEN/8)'(3) << {addr_ex[1], 1'b0};	// Lower or upper half.
		end
		MEM_SW: begin
			wdata_lane = store_data_ex;
			wstrb_lane = '1;
		end
		default: begin
			wdata_lane = '0;
			wstrb_lane = '0;
		end
		endcase
	end

endmodule

/* hw/mem_access_ctrl.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module mem_access_ctrl import cpu_pkg::*; (
	input	logic					clk,
	input	logic					reset,
	input	logic					valid_in,
	input	logic					ready_in,
	input	wb_src_t				wb_src_ex,
	input	mem_op_t				mem_op_ex,
	input	logic	[`XLEN-1:0]		addr_ex,
	input	logic	[`XLEN-1:0]		wdata_lane,
	input	logic	[`XLEN/8-1:0]	wstrb_lane,
	dmem_if.master					bus,
	output	logic					stall,
	output	logic					misaligned,
	output	logic	[`XLEN-1:0]		rsp_data,
	output	logic	[1:0]			rsp_code
);

	mem_state_t			state;
	mem_state_t			next_state;
	logic				is_store;
	logic				access;
	logic				resp_valid;
	logic				consume;
	logic	[`XLEN-1:0]	live_data;
	logic	[1:0]		live_code;
	logic	[`XLEN-1:0]	held_data;
	logic	[1:0]		held_code;

	assign is_store = is_store_op(mem_op_ex);

	always_comb begin
		misaligned = 1'b0;
		if (wb_src_ex == SEL_MEM) begin
			case (mem_op_ex)
			MEM_LH, MEM_LHU, MEM_SH:	misaligned = addr_ex[0];
			MEM_LW, MEM_SW:				misaligned = addr_ex[1:0] != 2'b00;
			default:					misaligned = 1'b0;
			endcase
		end
	end

	assign access		= valid_in && wb_src_ex == SEL_MEM && !misaligned;
	assign resp_valid	= is_store ? bus.bvalid : bus.rvalid;
	assign consume		= ready_in && (state == HOLD || (state == WAIT_RESP && resp_valid));

	always_comb begin
		next_state	= state;
		stall		= 1'b0;
		case (state)
		IDLE: begin
			stall = access;		// Request goes out next cycle.
			if (access)
				next_state = WAIT_RESP;
		end
		WAIT_RESP: begin
			stall = !resp_valid;
			if (resp_valid)
				next_state = ready_in ? IDLE : HOLD;
		end
		HOLD: begin
			if (ready_in)
				next_state = IDLE;
		end
		default: next_state = IDLE;
		endcase
	end

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			state		<= IDLE;
			bus.awvalid	<= 1'b0;
			bus.arvalid	<= 1'b0;
		end else begin
			state		<= next_state;
			bus.awvalid	<= state == IDLE && access && is_store;		// One-cycle pulse.
			bus.arvalid	<= state == IDLE && access && !is_store;
		end
	end

	// Response captured when writeback was not ready to take it.
	always_ff @(posedge clk) begin
		if (state == WAIT_RESP && resp_valid) begin
			held_data	<= live_data;
			held_code	<= live_code;
		end
	end

	assign live_data	= is_store ? '0 : bus.rdata;
	assign live_code	= is_store ? bus.bresp : bus.rresp;
	assign rsp_data		= state == HOLD ? held_data : live_data;
	assign rsp_code		= state == HOLD ? held_code : live_code;

	// EX holds its operands while stalled, so the request fields follow them.
	assign bus.awaddr	= addr_ex;
	assign bus.araddr	= addr_ex;
	assign bus.wdata	= wdata_lane;
	assign bus.wstrb	= wstrb_lane;
	assign bus.bready	= consume;
	assign bus.rready	= consume;

endmodule

/* hw/dmem_if.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

interface dmem_if;

	logic	[`XLEN-1:0]		awaddr;
	logic	[`XLEN-1:0]		wdata;
	logic	[`XLEN/8-1:0]	wstrb;
	logic					awvalid;	// Also qualifies wdata and wstrb.
	logic	[1:0]			bresp;
	logic					bvalid;
	logic					bready;
	logic	[`XLEN-1:0]		araddr;
	logic					arvalid;
	logic	[`XLEN-1:0]		rdata;
	logic	[1:0]			rresp;
	logic					rvalid;
	logic					rready;

	modport master (
		output	awaddr, wdata, wstrb, awvalid, bready, araddr, arvalid, rready,
		input	bresp, bvalid, rdata, rresp, rvalid
	);

	modport slave (
		input	awaddr, wdata, wstrb, awvalid, bready, araddr, arvalid, rready,
		output	bresp, bvalid, rdata, rresp, rvalid
	);

endinterface

/* hw/cpu_pkg.sv */
package cpu_pkg;

	// Memory operation carried with each instruction from EX.
	typedef enum logic [2:0] {
		MEM_LB	= 3'd0,
		MEM_LH	= 3'd1,
		MEM_LW	= 3'd2,
		MEM_LBU	= 3'd3,
		MEM_LHU	= 3'd4,
		MEM_SB	= 3'd5,
		MEM_SH	= 3'd6,
		MEM_SW	= 3'd7
	} mem_op_t;

	// Source of the value written back to rd.
	typedef enum logic [1:0] {
		SEL_ALU	= 2'd0,
		SEL_MEM	= 2'd1,		// Only this one reaches the data bus.
		SEL_PC4	= 2'd2,
		SEL_IMM	= 2'd3
	} wb_src_t;

	typedef enum logic [1:0] {
		IDLE		= 2'd0,
		WAIT_RESP	= 2'd1,
		HOLD		= 2'd2
	} mem_state_t;

	function automatic logic is_store_op(mem_op_t op);
		return op inside {MEM_SB, MEM_SH, MEM_SW};
	endfunction

endpackage

/* hw/cpu_settings.svh */
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Data and address width.
`define XLEN			32

// Data RAM size in 32-bit words.
`define DMEM_WORDS		256

// Cycles from a bus request to its response, at least 1.
`define DMEM_LATENCY	2

// Bus response codes.
`define RESP_OKAY		2'b00
`define RESP_SLVERR		2'b10

`endif
